// File: src/bp_pkg.sv
/*
  Shared types and constants for the branch prediction front end
  Byte addresses of 2-byte instructions, so bit 0 of any PC is expected to be 0
  Both branch formats carry signed word offsets that are relative to pc + 2
*/
package bp_pkg;

  //////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////
  typedef logic [15:0] addr_t;  // Byte address
  typedef logic [1:0]  ctr_t;   // Saturating counter. Bit 1 is the taken guess

  // Conditional branch view of an instruction word
  typedef struct packed {
    logic [3:0] opcode;
    logic [2:0] cond;    // Flag select in [1:0] and invert in [2]
    logic [8:0] offset;  // Signed word offset
  } b_fmt_t;

  // Unconditional jump view
  typedef struct packed {
    logic [3:0]  opcode;  // Same bits as b_fmt opcode
    logic [11:0] offset;  // Signed word offset
  } j_fmt_t;

  // One 16-bit word with both decodings
  typedef union packed {
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////
  localparam logic [3:0] op_bcc      = 4'hC;      // Conditional branch
  localparam logic [3:0] op_jmp      = 4'hD;      // Unconditional jump
  localparam logic [2:0] cond_always = 3'b111;    // Ignores the flags
  localparam addr_t      reset_pc    = 16'h0000;  // First fetch address

  // Counter step toward the actual outcome, stuck at 0 and 3
  function automatic ctr_t next_ctr(input ctr_t old_ctr, input logic taken);
    ctr_t new_ctr;
    new_ctr = old_ctr;
    if (taken) begin
      if (old_ctr != 2'd3) new_ctr = old_ctr + 2'd1;  // Toward strong taken
    end else begin
      if (old_ctr != 2'd0) new_ctr = old_ctr - 2'd1;  // Toward strong not taken
    end
    return new_ctr;
  endfunction

endpackage

// File: src/bp_ifaces.sv
/*
  Pipeline bundles between fetch, predictor and resolver
  No clock inside. Each block registers or computes its own side
*/
`timescale 1ns/1ps

//////////////////////////////////////////////////
// IF/ID pipeline register contents
//////////////////////////////////////////////////
interface ifid_if;
  logic           valid;        // Low after reset and after a flush
  bp_pkg::addr_t  pc;           // Fetch address of the held word
  bp_pkg::instr_u instr;        // Instruction word from memory
  bp_pkg::ctr_t   pred_ctr;     // BHT entry seen at fetch
  bp_pkg::addr_t  pred_target;  // BTB entry seen at fetch

  // Fetch side loads the register
  modport stage (
    output valid, pc, instr, pred_ctr, pred_target
  );

  // Decode side and predictor read it
  modport decode (
    input valid, pc, instr, pred_ctr, pred_target
  );
endinterface

//////////////////////////////////////////////////
// Branch resolution result
//////////////////////////////////////////////////
interface bp_update_if;
  logic          was_branch;     // Valid op_bcc or op_jmp in IF/ID
  logic          actual_taken;
  bp_pkg::addr_t actual_target;  // pc + 2 + 2 * offset
  logic          mispredict;     // Guess was wrong in direction or target
  bp_pkg::addr_t redirect_pc;    // Correct next fetch address

  modport resolver (
    output was_branch, actual_taken, actual_target, mispredict, redirect_pc
  );

  // Predictor writes its tables from these
  modport tables (
    input was_branch, actual_taken, actual_target, mispredict
  );

  // Fetch only needs the redirect
  modport fetch (
    input mispredict, redirect_pc
  );
endinterface

// File: src/fetch_stage.sv
/*
  Fetch stage. Holds the PC and loads the IF/ID register each enabled cycle
  Instruction memory must answer within the same cycle as fetch_pc
  A redirect flushes the word being fetched, giving a 1-cycle bubble
*/
`timescale 1ns/1ps

module fetch_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic           enable,         // Global stall when low
  input  bp_pkg::instr_u imem_data,      // Word at fetch_pc
  output bp_pkg::addr_t  fetch_pc,       // Also the memory address
  input  bp_pkg::ctr_t   lookup_ctr,     // BHT entry for fetch_pc
  input  bp_pkg::addr_t  lookup_target,  // BTB entry for fetch_pc
  ifid_if.stage          ifid,
  bp_update_if.fetch     upd
);

  //////////////////////////////////////////////////
  // Next PC selection
  //////////////////////////////////////////////////
  bp_pkg::addr_t pc_q;        // Current fetch address
  bp_pkg::addr_t seq_pc;      // Fall-through address
  bp_pkg::addr_t next_pc;
  logic          pred_taken;  // Predictor says jump

  assign fetch_pc   = pc_q;
  assign seq_pc     = pc_q + 16'd2;        // 2-byte instructions
  assign pred_taken = lookup_ctr[1];       // Upper counter bit

  // Redirect wins over the prediction, then fall through
  always_comb begin
    if (upd.mispredict) begin
      next_pc = upd.redirect_pc;           // Resolver correction
    end else if (pred_taken) begin
      next_pc = lookup_target;             // Follow the BTB
    end else begin
      next_pc = seq_pc;
    end
  end

  //////////////////////////////////////////////////
  // PC register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= bp_pkg::reset_pc;
    end else if (enable) begin
      pc_q <= next_pc;                     // Holds while stalled
    end
  end

  //////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////
  // Valid bit is control state
  always_ff @(posedge clk) begin
    if (rst) begin
      ifid.valid <= 1'b0;
    end else if (enable) begin
      // Word fetched alongside a mispredict is on the wrong path
      ifid.valid <= ~upd.mispredict;
    end
  end

  // Payload follows the fetch, valid tells whether it counts
  always_ff @(posedge clk) begin
    if (enable) begin
      ifid.pc          <= pc_q;
      ifid.instr       <= imem_data;
      ifid.pred_ctr    <= lookup_ctr;      // Carried for the counter update
      ifid.pred_target <= lookup_target;   // Carried for the target check
    end
  end

endmodule

// File: src/branch_predictor.sv
/*
  Untagged BHT and BTB indexed by PC bits [index_bits:1], so aliasing happens
  Lookup is combinational on fetch_pc and returns old data during a write
  BHT is written only on a mispredicted branch, BTB only on a taken branch
*/
`timescale 1ns/1ps

module branch_predictor #(
  parameter int index_bits = 3             // Table has 2**index_bits entries
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           enable,
  input  bp_pkg::addr_t  fetch_pc,
  output bp_pkg::ctr_t   lookup_ctr,
  output bp_pkg::addr_t  lookup_target,
  ifid_if.decode         ifid,             // PC and carried counter of resolved word
  bp_update_if.tables    upd
);

  localparam int entries = 1 << index_bits;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  bp_pkg::ctr_t  bht [entries];            // Direction counters
  bp_pkg::addr_t btb [entries];            // Last taken targets

  logic [index_bits-1:0] rd_idx;           // From the fetch PC
  logic [index_bits-1:0] wr_idx;           // From the IF/ID PC
  logic                  bht_we;
  logic                  btb_we;
  bp_pkg::ctr_t          bht_wdata;

  assign rd_idx = fetch_pc[index_bits:1];  // Bit 0 is always 0
  assign wr_idx = ifid.pc[index_bits:1];

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////
  assign lookup_ctr    = bht[rd_idx];
  assign lookup_target = btb[rd_idx];

  //////////////////////////////////////////////////
  // Update on resolution
  //////////////////////////////////////////////////
  // Learn a target only when the branch actually went there
  assign btb_we = enable & upd.was_branch & upd.actual_taken;

  // Counters move only when the guess was wrong
  // Non-branch mispredicts leave both tables alone
  assign bht_we = enable & upd.was_branch & upd.mispredict;

  // Step from the counter seen at fetch time
  assign bht_wdata = bp_pkg::next_ctr(ifid.pred_ctr, upd.actual_taken);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < entries; i++) begin
        bht[i] <= 2'd0;                    // Strong not taken
      end
    end else if (bht_we) begin
      bht[wr_idx] <= bht_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < entries; i++) begin
        btb[i] <= 16'h0000;
      end
    end else if (btb_we) begin
      btb[wr_idx] <= upd.actual_target;
    end
  end

endmodule

// File: src/branch_resolver.sv
/*
  Decodes the IF/ID word and resolves it against the condition flags
  Purely combinational. All outputs stay low or unused while IF/ID is invalid
  Targets wrap modulo 2**16
*/
`timescale 1ns/1ps

module branch_resolver (
  input  logic [3:0]      flags,           // Condition flags from execute
  ifid_if.decode          ifid,
  bp_update_if.resolver   upd
);

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  bp_pkg::instr_u instr;
  logic           is_bcc;
  logic           is_jmp;
  logic           cond_true;
  bp_pkg::addr_t  b_disp;                  // Byte displacement, b_fmt view
  bp_pkg::addr_t  j_disp;                  // Byte displacement, j_fmt view
  bp_pkg::addr_t  seq_pc;
  bp_pkg::addr_t  target;

  assign instr  = ifid.instr;
  assign is_bcc = (instr.b_fmt.opcode == bp_pkg::op_bcc);
  assign is_jmp = (instr.j_fmt.opcode == bp_pkg::op_jmp);  // Shared opcode bits

  // Sign extend the word offset and scale by 2
  assign b_disp = {{6{instr.b_fmt.offset[8]}}, instr.b_fmt.offset, 1'b0};
  assign j_disp = {{3{instr.j_fmt.offset[11]}}, instr.j_fmt.offset, 1'b0};

  assign seq_pc = ifid.pc + 16'd2;
  assign target = seq_pc + (is_jmp ? j_disp : b_disp);

  //////////////////////////////////////////////////
  // Condition
  //////////////////////////////////////////////////
  always_comb begin
    if (instr.b_fmt.cond == bp_pkg::cond_always) begin
      cond_true = 1'b1;
    end else begin
      // Pick one flag and optionally invert it
      cond_true = flags[instr.b_fmt.cond[1:0]] ^ instr.b_fmt.cond[2];
    end
  end

  //////////////////////////////////////////////////
  // Outcome and mispredict
  //////////////////////////////////////////////////
  logic pred_taken;
  logic taken;
  logic target_miss;

  assign pred_taken  = ifid.pred_ctr[1];   // Guess made at fetch
  assign taken       = ifid.valid & (is_jmp | (is_bcc & cond_true));
  assign target_miss = (target != ifid.pred_target);

  assign upd.was_branch    = ifid.valid & (is_bcc | is_jmp);
  assign upd.actual_taken  = taken;
  assign upd.actual_target = target;

  // Wrong direction, or right direction with a stale BTB target
  // A non-branch predicted taken also lands here
  assign upd.mispredict  = ifid.valid & ((taken != pred_taken) | (taken & target_miss));
  assign upd.redirect_pc = taken ? target : seq_pc;

endmodule

// File: src/bp_top.sv
/*
  Branch prediction front end. Fetch, predictor and resolver in lock step
  imem_data must be the word at imem_addr in the same cycle
  redirect marks a mispredict resolved in the IF/ID stage this cycle
*/
`timescale 1ns/1ps

module bp_top #(
  parameter int index_bits = 3             // BHT and BTB index width
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,              // Stall the whole front end when low
  input  logic [15:0] imem_data,
  input  logic [3:0]  flags,
  output logic [15:0] imem_addr,
  output logic        redirect
);

  //////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////
  ifid_if      ifid ();                    // IF/ID register
  bp_update_if upd ();                     // Resolution result

  bp_pkg::addr_t fetch_pc;
  bp_pkg::ctr_t  lookup_ctr;
  bp_pkg::addr_t lookup_target;

  fetch_stage u_fetch (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .imem_data     (imem_data),
    .fetch_pc      (fetch_pc),
    .lookup_ctr    (lookup_ctr),
    .lookup_target (lookup_target),
    .ifid          (ifid.stage),
    .upd           (upd.fetch)
  );

  branch_predictor #(
    .index_bits (index_bits)
  ) u_pred (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .fetch_pc      (fetch_pc),
    .lookup_ctr    (lookup_ctr),
    .lookup_target (lookup_target),
    .ifid          (ifid.decode),
    .upd           (upd.tables)
  );

  branch_resolver u_resolve (
    .flags (flags),
    .ifid  (ifid.decode),
    .upd   (upd.resolver)
  );

  assign imem_addr = fetch_pc;
  assign redirect  = upd.mispredict;       // Invalid IF/ID never redirects

endmodule

// File: verification/bp_sva.sv
/*
  Assertions on redirect, flush and stall, bound into bp_top
  fail_count holds the number of failed properties so far
*/
`timescale 1ns/1ps

module bp_sva (
  input logic        clk,
  input logic        rst,
  input logic        enable,
  input logic        redirect,
  input logic        ifid_valid,            // IF/ID valid inside bp_top
  input logic [15:0] imem_addr
);

  int fail_count = 0;

  //////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////
  // No redirect while IF/ID is cleared by reset
  reset_quiet: assert property (@(posedge clk) rst |=> !redirect)
    else begin
      fail_count++;
      $error("redirect high during or right after reset");
    end

  // Redirect flushes the word fetched with it
  flush_after_redirect: assert property (@(posedge clk) disable iff (rst)
    redirect && enable |=> !ifid_valid)
    else begin
      fail_count++;
      $error("IF/ID still valid after a redirect");
    end

  // Stall freezes the fetch address
  stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
    !enable |=> $stable(imem_addr))
    else begin
      fail_count++;
      $error("imem_addr moved while enable was low");
    end

endmodule

bind bp_top bp_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .enable     (enable),
  .redirect   (redirect),
  .ifid_valid (ifid.valid),
  .imem_addr  (imem_addr)
);

// File: verification/bp_tb.sv
/*
  Testbench for bp_top with a seeded random program and random flags
  A cycle model tracks PC, IF/ID and both tables and is compared every cycle
  Instruction memory is 128 words and mirrors every 256 bytes
*/
`timescale 1ns/1ps

module bp_tb;

  localparam int index_bits   = 3;
  localparam int entries      = 1 << index_bits;
  localparam int clk_period   = 40;          // ns
  localparam int reset_cycles = 5;
  localparam int run_cycles   = 5000;

  logic        clk;
  logic        rst;
  logic        enable;
  logic [15:0] imem_data;
  logic [3:0]  flags;
  logic [15:0] imem_addr;
  logic        redirect;

  integer      seed = 94717;
  logic [15:0] imem [128];                   // Combinational instruction memory

  // Model state
  bp_pkg::addr_t m_pc;
  logic          m_valid;
  bp_pkg::addr_t m_ifid_pc;
  logic [15:0]   m_instr;
  bp_pkg::ctr_t  m_ctr;                      // Counter carried in IF/ID
  bp_pkg::addr_t m_tgt;                      // Target carried in IF/ID
  bp_pkg::ctr_t  m_bht [entries];
  bp_pkg::addr_t m_btb [entries];

  // Model resolution of the word in IF/ID
  logic          r_branch;
  logic          r_taken;
  logic          r_mispredict;
  bp_pkg::addr_t r_target;
  bp_pkg::addr_t r_redirect_pc;

  bp_top #(.index_bits(index_bits)) dut (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .imem_data (imem_data),
    .flags     (flags),
    .imem_addr (imem_addr),
    .redirect  (redirect)
  );

  assign imem_data = imem[imem_addr[7:1]];   // Answers in the same cycle

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  // About one word in three is a branch, offsets kept small so code loops
  task automatic fill_imem;
    int off;
    for (int i = 0; i < 128; i++) begin
      if (rand_below(3) == 0) begin
        off = rand_below(24) - 10;
        if (off < 0 && off > -4) off = -off;  // No tight loop that never exits
        if (rand_below(2) == 0) begin
          imem[7'(i)] = {bp_pkg::op_bcc, 3'(rand_below(8)), 9'(off)};
        end else begin
          imem[7'(i)] = {bp_pkg::op_jmp, 12'(off)};
        end
      end else begin
        imem[7'(i)] = {4'(rand_below(12)), 12'(rand_below(4096))};  // Opcodes 0 to B
      end
    end
  endtask

  task automatic reset_model;
    m_pc      = 16'h0000;
    m_valid   = 1'b0;
    m_ifid_pc = 16'h0000;
    m_instr   = 16'h0000;
    m_ctr     = 2'd0;
    m_tgt     = 16'h0000;
    m_bht     = '{default: 2'd0};
    m_btb     = '{default: 16'h0000};
  endtask

  // Branch outcome from the IF/ID word and the current flags
  task automatic resolve;
    logic [3:0] op;
    logic [2:0] cond;
    logic       cond_ok;
    int         off;
    op   = m_instr[15:12];
    cond = m_instr[11:9];
    if (cond == 3'b111) cond_ok = 1'b1;
    else cond_ok = flags[cond[1:0]] ^ cond[2];
    if (op == bp_pkg::op_jmp) off = int'($signed(m_instr[11:0]));
    else off = int'($signed(m_instr[8:0]));
    r_target      = m_ifid_pc + 16'd2 + 16'(2 * off);  // Word offset from pc + 2
    r_branch      = m_valid && (op == bp_pkg::op_bcc || op == bp_pkg::op_jmp);
    r_taken       = m_valid && (op == bp_pkg::op_jmp || (op == bp_pkg::op_bcc && cond_ok));
    r_mispredict  = m_valid && ((r_taken != m_ctr[1]) || (r_taken && r_target != m_tgt));
    r_redirect_pc = r_taken ? r_target : m_ifid_pc + 16'd2;
  endtask

  // One clock edge of the model, tables read before they are written
  task automatic step_model;
    logic [index_bits-1:0] rd;
    logic [index_bits-1:0] wr;
    bp_pkg::ctr_t          l_ctr;
    bp_pkg::addr_t         l_tgt;
    if (enable) begin
      resolve;
      rd    = m_pc[index_bits:1];
      wr    = m_ifid_pc[index_bits:1];
      l_ctr = m_bht[rd];
      l_tgt = m_btb[rd];
      if (r_branch && r_taken) m_btb[wr] = r_target;
      if (r_branch && r_mispredict) m_bht[wr] = bp_pkg::next_ctr(m_ctr, r_taken);
      m_ifid_pc = m_pc;
      m_instr   = imem[m_pc[7:1]];
      m_ctr     = l_ctr;
      m_tgt     = l_tgt;
      m_valid   = !r_mispredict;               // Flush on redirect
      m_pc      = r_mispredict ? r_redirect_pc : (l_ctr[1] ? l_tgt : m_pc + 16'd2);
    end
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic compare_addr(input string name, input bp_pkg::addr_t expected,
                              input bp_pkg::addr_t actual);
    if (actual !== expected) begin
      $display("Error %s expected %h actual %h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Address mismatch");
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error %s expected %b actual %b", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Bit mismatch");
    end
  endtask

  // Bound properties that failed up to this cycle
  task automatic check_assertions(input int cyc);
    if (dut.u_sva.fail_count != 0) begin
      $display("An assertion failed by cycle %0d", cyc);
      $display(">>> FAIL");
      $fatal(1, "Assertion failure");
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and checking
  //////////////////////////////////////////////////
  initial begin
    rst    = 1'b1;
    enable = 1'b0;
    flags  = 4'h0;
    fill_imem;
    reset_model;
    repeat (reset_cycles) @(posedge clk);
    // First pass sees reset state, then rst drops on the same falling edge
    for (int cyc = 0; cyc < run_cycles; cyc++) begin
      @(negedge clk);
      resolve;                                 // Flags from the last drive
      compare_addr($sformatf("imem_addr cycle %0d", cyc), m_pc, imem_addr);
      compare_bit($sformatf("redirect cycle %0d", cyc), r_mispredict, redirect);
      check_assertions(cyc);
      rst    = 1'b0;
      enable = (rand_below(8) != 0);           // Stall about 1 cycle in 8
      flags  = 4'(rand_below(16));
      step_model;
    end
    $display(">>> PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #((reset_cycles + run_cycles + 100) * clk_period);
    $display("Timeout: the test did not finish in time");
    $display(">>> FAIL");
    $fatal(1, "Timeout");
  end

endmodule

// File: verilog.f
src/bp_pkg.sv
src/bp_ifaces.sv
src/fetch_stage.sv
src/branch_predictor.sv
src/branch_resolver.sv
src/bp_top.sv
verification/bp_sva.sv
verification/bp_tb.sv

// File: Makefile
# Verilator build for the branch prediction front end
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = bp_tb
FILE_LIST = verilog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)
